/* files.f */
+incdir+include
hw/pdu_cfg_pkg.sv
hw/pdu_types_pkg.sv
hw/pdu_gen.sv
hw/pdu_ring_buffer.sv
hw/pdu_subsystem.sv
verification/pdu_tb.sv

/* include/pdu_tb_model.svh */
`ifndef PDU_TB_MODEL_SVH
`define PDU_TB_MODEL_SVH

// expected ring contents, write pointer and free count.
pdu_types_pkg::flit_lite_t exp_ring [pdu_cfg_pkg::RB_DEPTH];
pdu_types_pkg::rb_addr_t   exp_wr_ptr = '0;
int                        exp_free = pdu_cfg_pkg::RB_DEPTH;
int                        error_count = 0;

// byte b of the input becomes byte 63-b of the output.
function automatic pdu_types_pkg::flit_data_t reverse_bytes(input pdu_types_pkg::flit_data_t d);
    pdu_types_pkg::flit_data_t r;
    for (int b = 0; b < pdu_cfg_pkg::FLIT_BYTES; b++) begin
        r[pdu_cfg_pkg::FLIT_WIDTH-1-8*b -: 8] = d[8*b +: 8];
    end
    return r;
endfunction

function automatic pdu_types_pkg::pdu_hdr_t build_header(
    input pdu_types_pkg::metadata_t meta,
    input int n,
    input int empty
);
    pdu_types_pkg::pdu_hdr_t h;
    h = '0;
    h.tuple = meta.tuple;
    h.prot = meta.prot;
    h.pdu_size = pdu_types_pkg::pdu_len_t'(pdu_cfg_pkg::FLIT_BYTES * n - empty);
    h.pdu_flit = pdu_types_pkg::pdu_len_t'(n);
    h.action = pdu_cfg_pkg::ACTION_CHECK;
    return h;
endfunction

// header at the base slot, payload behind it, then the pointer moves on.
function automatic void model_write_pdu(
    input pdu_types_pkg::metadata_t meta,
    input pdu_types_pkg::flit_data_t data [pdu_cfg_pkg::MAX_PDU_FLITS-1],
    input int n,
    input int empty
);
    pdu_types_pkg::rb_addr_t a;
    a = exp_wr_ptr;
    exp_ring[a] = {build_header(meta, n, empty), 1'b1, 1'b0};
    for (int i = 0; i < n; i++) begin
        a = a + 1'b1;
        exp_ring[a] = {reverse_bytes(data[i]), 1'b0, i == n - 1};
    end
    exp_wr_ptr = exp_wr_ptr + pdu_types_pkg::rb_addr_t'(n + 1);
    exp_free = exp_free - (n + 1);
endfunction

task automatic check(
    input string name,
    input logic [pdu_cfg_pkg::FLIT_WIDTH+1:0] expected,
    input logic [pdu_cfg_pkg::FLIT_WIDTH+1:0] actual
);
    if (actual !== expected) begin
        error_count++;
        $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
endtask

`endif

/* verification/pdu_tb.sv */
`timescale 1ns/100ps

module pdu_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_PACKETS = 40;
    localparam int HOLD_CYCLES = 20;
    // random packets plus those that fill the ring, with a margin on top.
    localparam int WATCHDOG_CYCLES = (NUM_PACKETS + 16) * pdu_cfg_pkg::MAX_PDU_FLITS * 6 + 500;

    logic                       clk;
    logic                       rst;
    logic                       in_sop;
    logic                       in_eop;
    pdu_types_pkg::flit_data_t  in_data;
    pdu_types_pkg::empty_t      in_empty;
    logic                       in_valid;
    logic                       in_ready;
    logic                       in_meta_valid;
    pdu_types_pkg::metadata_t   in_meta_data;
    logic                       in_meta_ready;
    pdu_types_pkg::rb_addr_t    rd_addr;
    logic                       rd_en;
    pdu_types_pkg::flit_lite_t  rd_data;
    logic                       release_valid;
    pdu_types_pkg::pdu_len_t    release_size;
    pdu_types_pkg::rb_addr_t    wr_ptr;
    pdu_types_pkg::pdu_len_t    free_slots;

    int seed = 12310;
    int pass_tests = 0;
    int fail_tests = 0;
    int meta_pulses = 0;
    int sent_pdus = 0;
    int pkt_len;
    int pkt_empty;
    pdu_types_pkg::metadata_t   pkt_meta;
    pdu_types_pkg::flit_data_t  pkt_data [pdu_cfg_pkg::MAX_PDU_FLITS-1];

    `include "pdu_tb_model.svh"

    pdu_subsystem DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ready is registered, so the falling edge sees a settled value.
    always @(negedge clk) begin
        if (in_meta_ready === 1'b1) begin
            meta_pulses++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic make_packet();
        pkt_len = 1 + ({$random(seed)} % (pdu_cfg_pkg::MAX_PDU_FLITS - 1));
        pkt_empty = {$random(seed)} % pdu_cfg_pkg::FLIT_BYTES;
        for (int i = 0; i < pkt_len; i++) begin
            for (int w = 0; w < pdu_cfg_pkg::FLIT_WIDTH / 32; w++) begin
                pkt_data[i][32*w +: 32] = $random(seed);
            end
        end
        pkt_meta = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    // metadata stays valid until the ready pulse.
    task automatic send_packet();
        logic taken;
        in_meta_data = pkt_meta;
        in_meta_valid = 1'b1;
        for (int i = 0; i < pkt_len; i++) begin
            in_valid = 1'b0;
            repeat ({$random(seed)} % 3) next_cycle();
            in_data = pkt_data[i];
            in_sop = (i == 0);
            in_eop = (i == pkt_len - 1);
            in_empty = in_eop ? pdu_types_pkg::empty_t'(pkt_empty) : '0;
            in_valid = 1'b1;
            taken = 1'b0;
            while (!taken) begin
                taken = in_ready;
                next_cycle();
            end
        end
        in_valid = 1'b0;
        in_sop = 1'b0;
        in_eop = 1'b0;
        while (in_meta_ready !== 1'b1) begin
            next_cycle();
        end
        in_meta_valid = 1'b0;
        sent_pdus++;
    endtask

    // the header lands two cycles after the ready pulse.
    task automatic verify_packet(input string name, input pdu_types_pkg::rb_addr_t base);
        next_cycle();
        next_cycle();
        check({name, " wr_ptr"}, exp_wr_ptr, wr_ptr);
        check({name, " free_slots"}, exp_free, free_slots);
        rd_en = 1'b1;
        for (int s = 0; s <= pkt_len; s++) begin
            rd_addr = base + pdu_types_pkg::rb_addr_t'(s);
            next_cycle();
            check($sformatf("%s slot %0d", name, s), exp_ring[rd_addr], rd_data);
        end
        rd_en = 1'b0;
    endtask

    task automatic release_pdu(input int size);
        release_valid = 1'b1;
        release_size = pdu_types_pkg::pdu_len_t'(size);
        next_cycle();
        release_valid = 1'b0;
        exp_free = exp_free + size;
        check("release free_slots", exp_free, free_slots);
    endtask

    task automatic hold_then_release(input int size);
        repeat (HOLD_CYCLES) begin
            next_cycle();
            check("backpressure in_ready", 1'b0, in_ready);
        end
        release_pdu(size);
    endtask

    task automatic run_packet(input string name, input bit do_release);
        pdu_types_pkg::rb_addr_t base;
        make_packet();
        base = exp_wr_ptr;
        send_packet();
        model_write_pdu(pkt_meta, pkt_data, pkt_len, pkt_empty);
        verify_packet(name, base);
        if (do_release) begin
            release_pdu(pkt_len + 1);
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        if (error_count == start_errors) begin
            pass_tests++;
            $display("%s: ok", name);
        end else begin
            fail_tests++;
            $display("%s: %0d errors", name, error_count - start_errors);
        end
    endtask

    initial begin
        int start;
        int withheld;
        pdu_types_pkg::rb_addr_t base;
        rst = 1'b1;
        in_sop = 1'b0;
        in_eop = 1'b0;
        in_data = '0;
        in_empty = '0;
        in_valid = 1'b0;
        in_meta_valid = 1'b0;
        in_meta_data = '0;
        rd_addr = '0;
        rd_en = 1'b0;
        release_valid = 1'b0;
        release_size = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        next_cycle();

        start = error_count;
        check("reset in_ready", 1'b0, in_ready);
        check("reset in_meta_ready", 1'b0, in_meta_ready);
        check("reset free_slots", pdu_cfg_pkg::RB_DEPTH, free_slots);
        check("reset wr_ptr", 0, wr_ptr);
        finish_test("reset", start);

        for (int k = 0; k < NUM_PACKETS; k++) begin
            start = error_count;
            run_packet($sformatf("packet %0d", k), 1'b1);
            finish_test($sformatf("packet %0d (%0d flits)", k, pkt_len), start);
        end

        // fill the ring without releasing, then hold one packet at the input.
        start = error_count;
        withheld = 0;
        while (exp_free >= pdu_cfg_pkg::ALMOST_FULL_LEVEL) begin
            run_packet("fill", 1'b0);
            withheld = withheld + pkt_len + 1;
        end
        make_packet();
        base = exp_wr_ptr;
        fork
            send_packet();
            hold_then_release(withheld);
        join
        model_write_pdu(pkt_meta, pkt_data, pkt_len, pkt_empty);
        verify_packet("held packet", base);
        release_pdu(pkt_len + 1);
        finish_test("backpressure", start);

        start = error_count;
        check("in_meta_ready pulse count", sent_pdus, meta_pulses);
        finish_test("completion pulses", start);

        $display("tests: %0d passed, %0d failed", pass_tests, fail_tests);
        if (fail_tests == 0 && error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* hw/pdu_subsystem.sv */
`timescale 1ns/100ps

module pdu_subsystem (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_sop,
    input  logic                        in_eop,
    input  pdu_types_pkg::flit_data_t   in_data,
    input  pdu_types_pkg::empty_t       in_empty,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic                        in_meta_valid,
    input  pdu_types_pkg::metadata_t    in_meta_data,
    output logic                        in_meta_ready,
    input  pdu_types_pkg::rb_addr_t     rd_addr,
    input  logic                        rd_en,
    output pdu_types_pkg::flit_lite_t   rd_data,
    input  logic                        release_valid,
    input  pdu_types_pkg::pdu_len_t     release_size,
    output pdu_types_pkg::rb_addr_t     wr_ptr,
    output pdu_types_pkg::pdu_len_t     free_slots
);

    pdu_types_pkg::flit_lite_t  rb_wr_data;
    pdu_types_pkg::rb_addr_t    rb_wr_addr;
    logic                       rb_wr_en;
    logic                       rb_almost_full;
    logic                       rb_update_valid;
    pdu_types_pkg::pdu_len_t    rb_update_size;

    pdu_gen u_pdu_gen (
        .clk             (clk),
        .rst             (rst),
        .in_sop          (in_sop),
        .in_eop          (in_eop),
        .in_data         (in_data),
        .in_empty        (in_empty),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_meta_valid   (in_meta_valid),
        .in_meta_data    (in_meta_data),
        .in_meta_ready   (in_meta_ready),
        .rb_wr_data      (rb_wr_data),
        .rb_wr_addr      (rb_wr_addr),
        .rb_wr_en        (rb_wr_en),
        .rb_wr_base_addr (wr_ptr),
        .rb_almost_full  (rb_almost_full),
        .rb_update_valid (rb_update_valid),
        .rb_update_size  (rb_update_size)
    );

    // the write pointer doubles as the base slot of the next PDU.
    pdu_ring_buffer u_pdu_ring_buffer (
        .clk           (clk),
        .rst           (rst),
        .wr_data       (rb_wr_data),
        .wr_addr       (rb_wr_addr),
        .wr_en         (rb_wr_en),
        .update_valid  (rb_update_valid),
        .update_size   (rb_update_size),
        .wr_base_addr  (wr_ptr),
        .almost_full   (rb_almost_full),
        .rd_addr       (rd_addr),
        .rd_en         (rd_en),
        .rd_data       (rd_data),
        .release_valid (release_valid),
        .release_size  (release_size),
        .free_slots    (free_slots)
    );

endmodule

/* hw/pdu_ring_buffer.sv */
`timescale 1ns/100ps

module pdu_ring_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  pdu_types_pkg::flit_lite_t   wr_data,
    input  pdu_types_pkg::rb_addr_t     wr_addr,
    input  logic                        wr_en,
    input  logic                        update_valid,
    input  pdu_types_pkg::pdu_len_t     update_size,
    output pdu_types_pkg::rb_addr_t     wr_base_addr,
    output logic                        almost_full,
    input  pdu_types_pkg::rb_addr_t     rd_addr,
    input  logic                        rd_en,
    output pdu_types_pkg::flit_lite_t   rd_data,
    input  logic                        release_valid,
    input  pdu_types_pkg::pdu_len_t     release_size,
    output pdu_types_pkg::pdu_len_t     free_slots
);

    pdu_types_pkg::flit_lite_t mem [pdu_cfg_pkg::RB_DEPTH];

    pdu_types_pkg::pdu_len_t   used_now;
    pdu_types_pkg::pdu_len_t   freed_now;
    pdu_types_pkg::rb_addr_t   ptr_step;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // the read is registered so data follows rd_en by one cycle.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_comb begin
        used_now = '0;
        freed_now = '0;
        if (update_valid) begin
            used_now = update_size;
        end
        if (release_valid) begin
            freed_now = release_size;
        end
    end

    // pointer wraps with the slot address width.
    assign ptr_step = update_size[pdu_cfg_pkg::PDU_AWIDTH-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_base_addr <= '0;
        end else if (update_valid) begin
            wr_base_addr <= wr_base_addr + ptr_step;
        end
    end

    // an update and a release may land together.
    always_ff @(posedge clk) begin
        if (rst) begin
            free_slots <= pdu_types_pkg::pdu_len_t'(pdu_cfg_pkg::RB_DEPTH);
        end else begin
            free_slots <= free_slots - used_now + freed_now;
        end
    end

    assign almost_full =
        (free_slots < pdu_types_pkg::pdu_len_t'(pdu_cfg_pkg::ALMOST_FULL_LEVEL));

endmodule

/* hw/pdu_gen.sv */
`timescale 1ns/100ps

module pdu_gen (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_sop,
    input  logic                        in_eop,
    input  pdu_types_pkg::flit_data_t   in_data,
    input  pdu_types_pkg::empty_t       in_empty,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic                        in_meta_valid,
    input  pdu_types_pkg::metadata_t    in_meta_data,
    output logic                        in_meta_ready,
    output pdu_types_pkg::flit_lite_t   rb_wr_data,
    output pdu_types_pkg::rb_addr_t     rb_wr_addr,
    output logic                        rb_wr_en,
    input  pdu_types_pkg::rb_addr_t     rb_wr_base_addr,
    input  logic                        rb_almost_full,
    output logic                        rb_update_valid,
    output pdu_types_pkg::pdu_len_t     rb_update_size
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        WRITE_HDR
    } state_t;

    state_t state;

    logic                       accept;
    pdu_types_pkg::pdu_len_t    flit_cnt;
    pdu_types_pkg::pdu_len_t    byte_cnt;
    pdu_types_pkg::pdu_len_t    flit_bytes;
    pdu_types_pkg::rb_addr_t    next_addr;
    pdu_types_pkg::pdu_hdr_t    hdr;

    // first pipeline stage ahead of the registered ring outputs.
    logic                       s1_valid;
    pdu_types_pkg::flit_data_t  s1_data;
    pdu_types_pkg::flit_data_t  s1_data_rev;
    pdu_types_pkg::rb_addr_t    s1_addr;
    logic                       s1_sop;
    logic                       s1_eop;
    logic                       s1_swap;

    assign in_ready = (state == WRITE);
    assign accept = in_valid && in_ready;

    // bytes carried by the incoming flit.
    always_comb begin
        flit_bytes = pdu_types_pkg::pdu_len_t'(pdu_cfg_pkg::FLIT_BYTES);
        if (in_eop) begin
            flit_bytes = flit_bytes - pdu_types_pkg::pdu_len_t'(in_empty);
        end
    end

    always_comb begin
        hdr.tuple = in_meta_data.tuple;
        hdr.prot = in_meta_data.prot;
        hdr.pdu_id = '0;
        hdr.num_ruleID = '0;
        hdr.pdu_size = byte_cnt;
        hdr.pdu_flit = flit_cnt;
        hdr.action = pdu_cfg_pkg::ACTION_CHECK;
        hdr.padding = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            s1_valid <= 1'b0;
            in_meta_ready <= 1'b0;
            rb_update_valid <= 1'b0;
            flit_cnt <= '0;
            byte_cnt <= '0;
            next_addr <= '0;
        end else begin
            s1_valid <= 1'b0;
            in_meta_ready <= 1'b0;
            rb_update_valid <= 1'b0;
            case (state)
                IDLE: begin
                    flit_cnt <= '0;
                    byte_cnt <= '0;
                    next_addr <= rb_wr_base_addr + 1'b1;
                    // wait out the ready pulse so stale metadata does not start a packet.
                    if (in_meta_valid && !in_meta_ready && !rb_almost_full) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (accept) begin
                        s1_valid <= 1'b1;
                        flit_cnt <= flit_cnt + 1'b1;
                        byte_cnt <= byte_cnt + flit_bytes;
                        next_addr <= next_addr + 1'b1;
                        if (in_eop) begin
                            state <= WRITE_HDR;
                        end
                    end
                end
                WRITE_HDR: begin
                    s1_valid <= 1'b1;
                    in_meta_ready <= 1'b1;
                    rb_update_valid <= 1'b1;
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WRITE_HDR) begin
            s1_data <= hdr;
            s1_addr <= rb_wr_base_addr;
            s1_sop <= 1'b1;
            s1_eop <= 1'b0;
            s1_swap <= 1'b0;
            // payload plus the header slot.
            rb_update_size <= flit_cnt + 1'b1;
        end else begin
            s1_data <= in_data;
            s1_addr <= next_addr;
            s1_sop <= 1'b0;
            s1_eop <= in_eop;
            s1_swap <= 1'b1;
        end
    end

    // byte 0 of the flit ends up in the top byte.
    always_comb begin
        for (int i = 0; i < pdu_cfg_pkg::FLIT_BYTES; i++) begin
            s1_data_rev[8*i +: 8] = s1_data[8*(pdu_cfg_pkg::FLIT_BYTES-1-i) +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rb_wr_en <= 1'b0;
        end else begin
            rb_wr_en <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        rb_wr_addr <= s1_addr;
        rb_wr_data.data <= s1_swap ? s1_data_rev : s1_data;
        rb_wr_data.sop <= s1_sop;
        rb_wr_data.eop <= s1_eop;
    end

endmodule

/* hw/pdu_types_pkg.sv */
package pdu_types_pkg;

    typedef logic [pdu_cfg_pkg::FLIT_WIDTH-1:0] flit_data_t;
    typedef logic [pdu_cfg_pkg::PDU_AWIDTH-1:0] rb_addr_t;
    typedef logic [pdu_cfg_pkg::EMPTY_WIDTH-1:0] empty_t;
    typedef logic [pdu_cfg_pkg::LEN_WIDTH-1:0] pdu_len_t;
    typedef logic [15:0] pdu_id_t;

    // flow 5-tuple without the protocol.
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } tuple_t;

    typedef struct packed {
        tuple_t      tuple;
        logic [31:0] prot;
    } metadata_t;

    // one ring slot.
    typedef struct packed {
        flit_data_t data;
        logic       sop;
        logic       eop;
    } flit_lite_t;

    // occupies the whole first slot of a PDU.
    typedef struct packed {
        tuple_t                                  tuple;
        logic [31:0]                             prot;
        pdu_id_t                                 pdu_id;
        logic [15:0]                             num_ruleID;
        pdu_len_t                                pdu_size;
        pdu_len_t                                pdu_flit;
        logic [7:0]                              action;
        logic [pdu_cfg_pkg::HDR_PAD_WIDTH-1:0]   padding;
    } pdu_hdr_t;

endpackage

/* hw/pdu_cfg_pkg.sv */
package pdu_cfg_pkg;

    // ring geometry.
    localparam int PDU_AWIDTH = 6;
    localparam int RB_DEPTH = 64;

    // largest PDU is eight payload flits plus the header.
    localparam int MAX_PDU_FLITS = 9;
    localparam int ALMOST_FULL_LEVEL = MAX_PDU_FLITS;

    // flit format.
    localparam int FLIT_BYTES = 64;
    localparam int FLIT_WIDTH = FLIT_BYTES * 8;
    localparam int EMPTY_WIDTH = 6;
    localparam int LEN_WIDTH = 16;

    // header fields before padding add up to 200 bits.
    localparam int HDR_USED_WIDTH = 200;
    localparam int HDR_PAD_WIDTH = FLIT_WIDTH - HDR_USED_WIDTH;

    // header action codes.
    localparam logic [7:0] ACTION_CHECK = 8'd1;

endpackage
